//--- design/axi_lite_pkg.sv
`default_nettype none

// channel types shared by the AXI-lite slave port and the top level
package axi_lite_pkg;

    // response code on bresp and rresp
    // this slave only ever answers OKAY
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // signals driven by the bus master
    typedef struct packed {
        // write address channel
        logic [15:0] awaddr;
        logic        awvalid;
        // write data channel, strobes are not used by the slave
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        // write response channel
        logic        bready;
        // read address channel
        logic [15:0] araddr;
        logic        arvalid;
        // read data channel
        logic        rready;
    } axi_req_t;

    // signals driven by the slave
    typedef struct packed {
        logic        awready;
        logic        wready;
        axi_resp_e   bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        axi_resp_e   rresp;
        logic        rvalid;
    } axi_rsp_t;

endpackage

`default_nettype wire

//--- design/rx_regs_pkg.sv
`default_nettype none

// register map of the sync receiver and the status it exposes
package rx_regs_pkg;

    // core version word
    localparam logic [31:0] PCORE_VERSION = 32'h00040069;
    // "RX~~" in ascii
    localparam logic [31:0] RX_MAGIC = 32'h52587E7E;
    localparam logic [31:0] RX_PATTERN = 32'h69696969;

    // highest physical cell id, sets the width of the n_id field
    localparam int N_ID_MAX = 1007;
    localparam int N_ID_WIDTH = $clog2(N_ID_MAX);

    // word index of each register (byte address bits 10:2)
    typedef enum logic [8:0] {
        REG_VERSION   = 9'h000,
        REG_ID        = 9'h001,
        REG_SCRATCH   = 9'h002,
        REG_MAGIC     = 9'h003,
        REG_PATTERN   = 9'h004,
        REG_FS_STATE  = 9'h005,
        REG_RX_SIGNAL = 9'h006,
        REG_N_ID_2    = 9'h007,
        REG_N_ID      = 9'h008,
        REG_MISMATCH  = 9'h009,
        REG_DET_COUNT = 9'h00A,
        REG_LAST_DET  = 9'h00B,
        REG_CONTROL   = 9'h00C
    } reg_addr_e;

    // live status from the receiver datapath
    typedef struct packed {
        logic [1:0]            fs_state;
        logic [31:0]           rx_signal;
        logic [1:0]            n_id_2;
        logic [N_ID_WIDTH-1:0] n_id;
        logic signed [7:0]     sample_cnt_mismatch;
    } rx_status_t;

    // single-cycle requests from the bus bridge to the register map
    typedef struct packed {
        logic        wreq;
        logic [8:0]  waddr;
        logic [31:0] wdata;
        logic        rreq;
        logic [8:0]  raddr;
    } reg_req_t;

endpackage

`default_nettype wire

//--- design/axi_lite_slave.sv
`timescale 1ns/1ps
`default_nettype none

// AXI-lite slave that serves one transaction at a time and turns it into
// a single-cycle write or read request towards the register map
module axi_lite_slave #(
    parameter int ADDRESS_WIDTH = 11
) (
    input  wire logic                   clk_i,
    input  wire logic                   reset_ni,

    input  wire axi_lite_pkg::axi_req_t axi_req_i,
    output axi_lite_pkg::axi_rsp_t      axi_rsp_o,

    output rx_regs_pkg::reg_req_t       reg_req_o,
    input  wire logic [31:0]            rdata_i,
    input  wire logic                   wack_i,
    input  wire logic                   rack_i
);

    typedef enum logic [2:0] {
        IDLE,
        WRITE_REQ,
        WRITE_WAIT,
        WRITE_RESP,
        READ_REQ,
        READ_WAIT,
        READ_RESP
    } state_e;

    state_e      state_q;
    logic        aw_ready_q;
    logic        ar_ready_q;
    logic        aw_hs;
    logic        ar_hs;
    logic [8:0]  addr_q;
    logic [31:0] wdata_q;
    logic [31:0] rdata_q;

    // address and data of a write transfer together, AXI handshake on each channel
    assign aw_hs = aw_ready_q && axi_req_i.awvalid && axi_req_i.wvalid;
    assign ar_hs = ar_ready_q && axi_req_i.arvalid;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= IDLE;
            aw_ready_q <= 1'b0;
            ar_ready_q <= 1'b0;
        end else begin
            // readies are one-cycle pulses
            aw_ready_q <= 1'b0;
            ar_ready_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (aw_hs) begin
                        state_q <= WRITE_REQ;
                    end else if (ar_hs) begin
                        state_q <= READ_REQ;
                    end else if (!aw_ready_q && !ar_ready_q) begin
                        // write has priority over a pending read
                        if (axi_req_i.awvalid && axi_req_i.wvalid) begin
                            aw_ready_q <= 1'b1;
                        end else if (axi_req_i.arvalid) begin
                            ar_ready_q <= 1'b1;
                        end
                    end
                end
                WRITE_REQ: state_q <= WRITE_WAIT;
                WRITE_WAIT: begin
                    if (wack_i) begin
                        state_q <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (axi_req_i.bready) begin
                        state_q <= IDLE;
                    end
                end
                READ_REQ: state_q <= READ_WAIT;
                READ_WAIT: begin
                    if (rack_i) begin
                        state_q <= READ_RESP;
                    end
                end
                READ_RESP: begin
                    if (axi_req_i.rready) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // word index and write data captured on acceptance
    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            addr_q  <= 9'(axi_req_i.awaddr[ADDRESS_WIDTH-1:2]);
            wdata_q <= axi_req_i.wdata;
        end else if (ar_hs) begin
            addr_q <= 9'(axi_req_i.araddr[ADDRESS_WIDTH-1:2]);
        end
    end

    // read data held here so it stays stable while rvalid waits
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            rdata_q <= '0;
        end else if (rack_i) begin
            rdata_q <= rdata_i;
        end
    end

    always_comb begin
        reg_req_o.wreq  = (state_q == WRITE_REQ);
        reg_req_o.waddr = addr_q;
        reg_req_o.wdata = wdata_q;
        reg_req_o.rreq  = (state_q == READ_REQ);
        reg_req_o.raddr = addr_q;
    end

    always_comb begin
        axi_rsp_o.awready = aw_ready_q;
        axi_rsp_o.wready  = aw_ready_q;
        axi_rsp_o.bresp   = axi_lite_pkg::OKAY;
        axi_rsp_o.bvalid  = (state_q == WRITE_RESP);
        axi_rsp_o.arready = ar_ready_q;
        axi_rsp_o.rdata   = rdata_q;
        axi_rsp_o.rresp   = axi_lite_pkg::OKAY;
        axi_rsp_o.rvalid  = (state_q == READ_RESP);
    end

endmodule

`default_nettype wire

//--- design/receiver_regmap.sv
`timescale 1ns/1ps
`default_nettype none

// register decode for the sync receiver
// reads and writes are acknowledged one cycle after their request
module receiver_regmap #(
    parameter logic [31:0] ID = 32'h0,
    parameter int COUNT_WIDTH = 16
) (
    input  wire logic                               clk_i,
    input  wire logic                               reset_ni,

    input  wire rx_regs_pkg::reg_req_t              reg_req_i,
    output logic [31:0]                             rdata_o,
    output logic                                    wack_o,
    output logic                                    rack_o,

    input  wire rx_regs_pkg::rx_status_t            status_i,
    input  wire logic [COUNT_WIDTH-1:0]             det_count_i,
    input  wire logic [rx_regs_pkg::N_ID_WIDTH-1:0] last_n_id_i,
    input  wire logic [1:0]                         last_n_id_2_i,
    output logic                                    stats_clear_o
);

    logic [31:0] scratch_q;
    logic [31:0] last_det;
    logic [31:0] rd_value;

    // clear takes effect on the same edge as the write request
    assign stats_clear_o = reg_req_i.wreq && reg_req_i.wdata[0]
        && (reg_req_i.waddr == rx_regs_pkg::REG_CONTROL);

    // n_id in the low bits, n_id_2 at 17:16
    always_comb begin
        last_det = '0;
        last_det[rx_regs_pkg::N_ID_WIDTH-1:0] = last_n_id_i;
        last_det[17:16] = last_n_id_2_i;
    end

    always_comb begin
        case (reg_req_i.raddr)
            rx_regs_pkg::REG_VERSION:   rd_value = rx_regs_pkg::PCORE_VERSION;
            rx_regs_pkg::REG_ID:        rd_value = ID;
            rx_regs_pkg::REG_SCRATCH:   rd_value = scratch_q;
            rx_regs_pkg::REG_MAGIC:     rd_value = rx_regs_pkg::RX_MAGIC;
            rx_regs_pkg::REG_PATTERN:   rd_value = rx_regs_pkg::RX_PATTERN;
            rx_regs_pkg::REG_FS_STATE:  rd_value = {30'd0, status_i.fs_state};
            rx_regs_pkg::REG_RX_SIGNAL: rd_value = status_i.rx_signal;
            rx_regs_pkg::REG_N_ID_2:    rd_value = {30'd0, status_i.n_id_2};
            rx_regs_pkg::REG_N_ID:      rd_value = 32'(status_i.n_id);
            // the mismatch is a signed sample count
            rx_regs_pkg::REG_MISMATCH: begin
                rd_value = {{24{status_i.sample_cnt_mismatch[7]}},
                            status_i.sample_cnt_mismatch};
            end
            rx_regs_pkg::REG_DET_COUNT: rd_value = 32'(det_count_i);
            rx_regs_pkg::REG_LAST_DET:  rd_value = last_det;
            // control is write-only, unknown indices land here too
            default:                    rd_value = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wack_o    <= 1'b0;
            rack_o    <= 1'b0;
            rdata_o   <= '0;
            scratch_q <= '0;
        end else begin
            wack_o <= reg_req_i.wreq;
            rack_o <= reg_req_i.rreq;
            // status is sampled on the request cycle
            if (reg_req_i.rreq) begin
                rdata_o <= rd_value;
            end
            if (reg_req_i.wreq && (reg_req_i.waddr == rx_regs_pkg::REG_SCRATCH)) begin
                scratch_q <= reg_req_i.wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/detect_stats.sv
`timescale 1ns/1ps
`default_nettype none

// counts sync detections and keeps the cell identity of the latest one
module detect_stats #(
    parameter int COUNT_WIDTH = 16
) (
    input  wire logic                               clk_i,
    input  wire logic                               reset_ni,

    input  wire logic                               detect_valid_i,
    input  wire logic [rx_regs_pkg::N_ID_WIDTH-1:0] n_id_i,
    input  wire logic [1:0]                         n_id_2_i,
    input  wire logic                               clear_i,

    output logic [COUNT_WIDTH-1:0]                  count_o,
    output logic [rx_regs_pkg::N_ID_WIDTH-1:0]      last_n_id_o,
    output logic [1:0]                              last_n_id_2_o
);

    logic count_full;

    // counter stops at all ones
    assign count_full = &count_o;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            count_o <= '0;
        end else if (clear_i) begin
            // clear wins over a detection on the same edge
            count_o <= '0;
        end else if (detect_valid_i && !count_full) begin
            count_o <= count_o + 1'b1;
        end
    end

    // capture follows every strobe, even once the counter has saturated
    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            last_n_id_o   <= '0;
            last_n_id_2_o <= '0;
        end else if (detect_valid_i) begin
            last_n_id_o   <= n_id_i;
            last_n_id_2_o <= n_id_2_i;
        end
    end

endmodule

`default_nettype wire

//--- design/receiver_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

// register block of the sync receiver, reachable over AXI-lite
module receiver_ctrl_top #(
    parameter logic [31:0] ID = 32'h0,
    parameter int ADDRESS_WIDTH = 11,
    parameter int COUNT_WIDTH = 16
) (
    input  wire logic                    clk_i,
    input  wire logic                    reset_ni,

    input  wire axi_lite_pkg::axi_req_t  axi_req_i,
    output axi_lite_pkg::axi_rsp_t       axi_rsp_o,

    input  wire rx_regs_pkg::rx_status_t status_i,
    input  wire logic                    detect_valid_i
);

    rx_regs_pkg::reg_req_t                reg_req;
    logic [31:0]                          rdata;
    logic                                 wack;
    logic                                 rack;
    logic                                 stats_clear;
    logic [COUNT_WIDTH-1:0]               det_count;
    logic [rx_regs_pkg::N_ID_WIDTH-1:0]   last_n_id;
    logic [1:0]                           last_n_id_2;

    axi_lite_slave #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH)
    ) axi_lite_slave_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .axi_req_i(axi_req_i),
        .axi_rsp_o(axi_rsp_o),
        .reg_req_o(reg_req),
        .rdata_i(rdata),
        .wack_i(wack),
        .rack_i(rack)
    );

    receiver_regmap #(
        .ID(ID),
        .COUNT_WIDTH(COUNT_WIDTH)
    ) receiver_regmap_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .reg_req_i(reg_req),
        .rdata_o(rdata),
        .wack_o(wack),
        .rack_o(rack),
        .status_i(status_i),
        .det_count_i(det_count),
        .last_n_id_i(last_n_id),
        .last_n_id_2_i(last_n_id_2),
        .stats_clear_o(stats_clear)
    );

    // detections record the cell identity currently reported by the receiver
    detect_stats #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) detect_stats_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .detect_valid_i(detect_valid_i),
        .n_id_i(status_i.n_id),
        .n_id_2_i(status_i.n_id_2),
        .clear_i(stats_clear),
        .count_o(det_count),
        .last_n_id_o(last_n_id),
        .last_n_id_2_o(last_n_id_2)
    );

endmodule

`default_nettype wire

//--- test/receiver_ctrl_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// handshake rules of the AXI-lite slave port
module receiver_ctrl_assertions (
    input wire logic                   clk_i,
    input wire logic                   reset_ni,
    input wire axi_lite_pkg::axi_req_t axi_req_i,
    input wire axi_lite_pkg::axi_rsp_t axi_rsp_o
);

    // a response stays up until the master takes it
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        axi_rsp_o.bvalid && !axi_req_i.bready |=> axi_rsp_o.bvalid)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        axi_rsp_o.rvalid && !axi_req_i.rready |=> axi_rsp_o.rvalid)
        else $error("rvalid dropped before rready");

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        axi_rsp_o.rvalid && !axi_req_i.rready |=> $stable(axi_rsp_o.rdata))
        else $error("rdata changed while rvalid waited");

    // address and data of a write are taken together in a one-cycle pulse after both valids
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (axi_rsp_o.awready || axi_rsp_o.wready) |->
            (axi_rsp_o.awready && axi_rsp_o.wready
             && $past(axi_req_i.awvalid && axi_req_i.wvalid)) ##1 !axi_rsp_o.awready)
        else $error("awready and wready not raised together for one cycle");

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        (axi_rsp_o.bvalid || axi_rsp_o.rvalid) |-> !axi_rsp_o.awready && !axi_rsp_o.arready)
        else $error("address accepted while a response is pending");

endmodule

bind axi_lite_slave receiver_ctrl_assertions receiver_ctrl_assertions_i (
    .clk_i(clk_i),
    .reset_ni(reset_ni),
    .axi_req_i(axi_req_i),
    .axi_rsp_o(axi_rsp_o)
);

`default_nettype wire

//--- test/receiver_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module receiver_ctrl_tb;

    localparam logic [31:0] DUT_ID = 32'h5A5A0001;
    localparam int COUNT_WIDTH = 16;
    localparam int COUNT_MAX = 2 ** COUNT_WIDTH - 1;
    localparam int TIMEOUT = 50;

    logic                    clk_i;
    logic                    reset_ni;
    axi_lite_pkg::axi_req_t  axi_req;
    axi_lite_pkg::axi_rsp_t  axi_rsp;
    rx_regs_pkg::rx_status_t status;
    logic                    detect_valid;
    logic [31:0]             lcg_state;

    // model of the register contents
    logic [31:0]                        scratch_model;
    int                                 det_count_model;
    logic [rx_regs_pkg::N_ID_WIDTH-1:0] last_n_id_model;
    logic [1:0]                         last_n_id_2_model;

    int          check_count;
    int          error_count;
    int          timeout_count;
    logic [31:0] obs_q[$];
    logic [31:0] exp_q[$];
    logic [8:0]  idx_q[$];

    receiver_ctrl_top #(
        .ID(DUT_ID),
        .ADDRESS_WIDTH(11),
        .COUNT_WIDTH(COUNT_WIDTH)
    ) receiver_ctrl_top_i (
        .clk_i(clk_i),
        .reset_ni(reset_ni),
        .axi_req_i(axi_req),
        .axi_rsp_o(axi_rsp),
        .status_i(status),
        .detect_valid_i(detect_valid)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rx_regs_pkg::rx_status_t random_status();
        rx_regs_pkg::rx_status_t st;
        logic [31:0] r;
        r = next_random();
        st.fs_state = r[1:0];
        st.n_id_2 = r[3:2];
        st.n_id = 10'(r[31:12] % (rx_regs_pkg::N_ID_MAX + 1));
        st.sample_cnt_mismatch = r[11:4];
        st.rx_signal = next_random();
        return st;
    endfunction

    // value each register should read, from the register rules
    function automatic logic [31:0] expected_read(input logic [8:0] index);
        int mismatch;
        mismatch = $signed(status.sample_cnt_mismatch);
        case (index)
            rx_regs_pkg::REG_VERSION:   return rx_regs_pkg::PCORE_VERSION;
            rx_regs_pkg::REG_ID:        return DUT_ID;
            rx_regs_pkg::REG_SCRATCH:   return scratch_model;
            rx_regs_pkg::REG_MAGIC:     return rx_regs_pkg::RX_MAGIC;
            rx_regs_pkg::REG_PATTERN:   return rx_regs_pkg::RX_PATTERN;
            rx_regs_pkg::REG_FS_STATE:  return 32'(status.fs_state);
            rx_regs_pkg::REG_RX_SIGNAL: return status.rx_signal;
            rx_regs_pkg::REG_N_ID_2:    return 32'(status.n_id_2);
            rx_regs_pkg::REG_N_ID:      return 32'(status.n_id);
            rx_regs_pkg::REG_MISMATCH:  return 32'(mismatch);
            rx_regs_pkg::REG_DET_COUNT: return 32'(det_count_model);
            rx_regs_pkg::REG_LAST_DET:  return (32'(last_n_id_2_model) << 16) | 32'(last_n_id_model);
            default:                    return 32'h0;
        endcase
    endfunction

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Error at %0t: the DUT gave no %s within %0d cycles", $time, what, TIMEOUT);
    endtask

    task automatic axi_write(input logic [8:0] index, input logic [31:0] data);
        int   cycles;
        logic accepted;
        @(posedge clk_i);
        axi_req.awaddr <= {5'd0, index, 2'b00};
        axi_req.wdata <= data;
        axi_req.wstrb <= 4'hf;
        axi_req.awvalid <= 1'b1;
        axi_req.wvalid <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!axi_rsp.awready && cycles < TIMEOUT);
        accepted = axi_rsp.awready;
        // both write channels are taken on the same cycle
        if (axi_rsp.wready !== axi_rsp.awready) begin
            error_count++;
            $display("Fail at %0t: awready %0b but wready %0b", $time,
                     axi_rsp.awready, axi_rsp.wready);
        end
        @(posedge clk_i);
        axi_req.awvalid <= 1'b0;
        axi_req.wvalid <= 1'b0;
        if (!accepted) begin
            report_timeout("awready");
            return;
        end
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!axi_rsp.bvalid && cycles < TIMEOUT);
        if (!axi_rsp.bvalid) begin
            report_timeout("bvalid");
            return;
        end
        // response held back for a while
        repeat (int'(next_random() % 12)) @(posedge clk_i);
        @(posedge clk_i);
        axi_req.bready <= 1'b1;
        @(negedge clk_i);
        if (!axi_rsp.bvalid || axi_rsp.bresp != axi_lite_pkg::OKAY) begin
            error_count++;
            $display("Fail at %0t: write response bvalid %0b bresp %0d", $time,
                     axi_rsp.bvalid, axi_rsp.bresp);
        end
        @(posedge clk_i);
        axi_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [8:0] index);
        int   cycles;
        logic accepted;
        @(posedge clk_i);
        axi_req.araddr <= {5'd0, index, 2'b00};
        axi_req.arvalid <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!axi_rsp.arready && cycles < TIMEOUT);
        accepted = axi_rsp.arready;
        @(posedge clk_i);
        axi_req.arvalid <= 1'b0;
        if (!accepted) begin
            report_timeout("arready");
            return;
        end
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!axi_rsp.rvalid && cycles < TIMEOUT);
        if (!axi_rsp.rvalid) begin
            report_timeout("rvalid");
            return;
        end
        repeat (int'(next_random() % 12)) @(posedge clk_i);
        @(posedge clk_i);
        axi_req.rready <= 1'b1;
        @(negedge clk_i);
        if (!axi_rsp.rvalid || axi_rsp.rresp != axi_lite_pkg::OKAY) begin
            error_count++;
            $display("Fail at %0t: read response rvalid %0b rresp %0d", $time,
                     axi_rsp.rvalid, axi_rsp.rresp);
        end
        obs_q.push_back(axi_rsp.rdata);
        exp_q.push_back(expected_read(index));
        idx_q.push_back(index);
        @(posedge clk_i);
        axi_req.rready <= 1'b0;
    endtask

    // random status each cycle, a strobe on about half of them
    task automatic drive_detections(input int count);
        rx_regs_pkg::rx_status_t st;
        logic strobe;
        for (int i = 0; i < count; i++) begin
            st = random_status();
            strobe = next_random() > 32'h7fffffff;
            @(posedge clk_i);
            status <= st;
            detect_valid <= strobe;
            if (strobe) begin
                if (det_count_model < COUNT_MAX) begin
                    det_count_model++;
                end
                last_n_id_model = st.n_id;
                last_n_id_2_model = st.n_id_2;
            end
        end
        @(posedge clk_i);
        detect_valid <= 1'b0;
    endtask

    always @(posedge clk_i) begin : compare_reads
        logic [31:0] obs;
        logic [31:0] exp;
        logic [8:0]  idx;
        while (obs_q.size() != 0) begin
            obs = obs_q.pop_front();
            exp = exp_q.pop_front();
            idx = idx_q.pop_front();
            check_count++;
            if (obs !== exp) begin
                error_count++;
                $display("Fail at %0t: index 0x%03h read 0x%08h, expected 0x%08h",
                         $time, idx, obs, exp);
            end
        end
    end

    initial begin : stimulus
        logic [31:0] data;
        logic [8:0]  index;
        lcg_state = 32'hbb65f00b;
        axi_req = '0;
        status = '0;
        detect_valid = 1'b0;
        reset_ni = 1'b0;
        scratch_model = '0;
        det_count_model = 0;
        last_n_id_model = '0;
        last_n_id_2_model = '0;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        repeat (4) @(posedge clk_i);
        reset_ni <= 1'b1;

        // fixed words and reset values
        axi_read(rx_regs_pkg::REG_VERSION);
        axi_read(rx_regs_pkg::REG_ID);
        axi_read(rx_regs_pkg::REG_MAGIC);
        axi_read(rx_regs_pkg::REG_PATTERN);
        axi_read(rx_regs_pkg::REG_SCRATCH);
        axi_read(rx_regs_pkg::REG_DET_COUNT);

        repeat (8) begin
            data = next_random();
            axi_write(rx_regs_pkg::REG_SCRATCH, data);
            scratch_model = data;
            axi_read(rx_regs_pkg::REG_SCRATCH);
        end

        // writes that must not change anything
        axi_write(rx_regs_pkg::REG_VERSION, next_random());
        axi_write(rx_regs_pkg::REG_MAGIC, next_random());
        axi_write(rx_regs_pkg::REG_N_ID, next_random());
        repeat (4) begin
            index = 9'(13 + next_random() % 499);
            axi_write(index, next_random());
            axi_read(index);
        end
        axi_read(rx_regs_pkg::REG_SCRATCH);
        axi_read(rx_regs_pkg::REG_VERSION);
        axi_read(rx_regs_pkg::REG_MAGIC);
        axi_read(rx_regs_pkg::REG_CONTROL);

        // live status, held while its registers are read
        repeat (6) begin
            @(posedge clk_i);
            status <= random_status();
            for (int i = 5; i <= 9; i++) begin
                axi_read(9'(i));
            end
        end

        repeat (3) begin
            drive_detections(int'(next_random() % 40));
            axi_read(rx_regs_pkg::REG_DET_COUNT);
            axi_read(rx_regs_pkg::REG_LAST_DET);
        end

        // control with bit 0 low keeps the statistics
        axi_write(rx_regs_pkg::REG_CONTROL, 32'h0000_0000);
        axi_read(rx_regs_pkg::REG_DET_COUNT);
        axi_write(rx_regs_pkg::REG_CONTROL, next_random() | 32'h1);
        det_count_model = 0;
        last_n_id_model = '0;
        last_n_id_2_model = '0;
        axi_read(rx_regs_pkg::REG_DET_COUNT);
        axi_read(rx_regs_pkg::REG_LAST_DET);
        drive_detections(25);
        axi_read(rx_regs_pkg::REG_DET_COUNT);
        axi_read(rx_regs_pkg::REG_LAST_DET);

        repeat (2) @(posedge clk_i);
        $display("reads checked %0d, errors %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/axi_lite_pkg.sv
design/rx_regs_pkg.sv
design/axi_lite_slave.sv
design/receiver_regmap.sv
design/detect_stats.sv
design/receiver_ctrl_top.sv
test/receiver_ctrl_assertions.sv
test/receiver_ctrl_tb.sv
